// ==== build.f ====
+incdir+rtl
rtl/spi_flash_pkg.sv
rtl/flash_regs.sv
rtl/spi_sequencer.sv
rtl/dma_writer.sv
rtl/spi_flash_top.sv
verif/clock_gen.sv
verif/flash_model.sv
verif/tb_spi_flash.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the SPI flash testbench with Verilator and runs it.
# The exit status is zero only when the run prints the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_spi_flash -f build.f -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if grep -qx "TEST OK" <<< "$output"; then
	exit 0
else
	echo "simulation did not pass"
	exit 1
fi

// ==== verif/tb_spi_flash.sv ====
/*
 * Testbench for spi_flash_top. Each table row is one job; wready stalls come from an LCG.
 * Flash data follows (a * 7 + 3) per byte address a, first byte low in each word.
 */
`timescale 1ns/1ps
`include "spi_flash_consts.svh"

module tb_spi_flash;
	localparam int          NUM_TESTS      = 7;
	localparam int          TIMEOUT_MARGIN = 2000;
	localparam logic [31:0] LCG_SEED       = 32'h65f4;

	typedef struct packed {
		logic [15:0] cmd;
		logic [22:0] waddr;
		logic [15:0] count;
		logic [15:0] base;
	} test_vec_t;

	logic        CLK, RSTb;
	logic [3:0]  ADDRESS;
	logic [15:0] DATA_IN, DATA_OUT;
	logic        WR;
	logic        MOSI, MISO, SCK, CSb;
	logic        wvalid, wready;
	logic [15:0] memory_address, memory_data;
	logic [15:0] frame_count, wake_count, last_bits;
	logic [7:0]  last_opcode;
	logic [23:0] last_addr;

	string       test_name [NUM_TESTS];
	test_vec_t   test_vec  [NUM_TESTS];
	string       cur_name;
	int          mismatches    = 0;
	int          faults        = 0;
	logic [15:0] last_word     = '0;
	logic [31:0] rng;
	int unsigned wvalid_cycles = 0;
	logic [15:0] acc_addr [$];
	logic [15:0] acc_data [$];

	clock_gen clkgen (.CLK(CLK), .RSTb(RSTb));

	flash_model flash (
		.CSb(CSb), .SCK(SCK), .MOSI(MOSI), .MISO(MISO),
		.frame_count(frame_count), .wake_count(wake_count),
		.last_opcode(last_opcode), .last_addr(last_addr), .last_bits(last_bits)
	);

	spi_flash_top UUT (
		.CLK(CLK), .RSTb(RSTb),
		.ADDRESS(ADDRESS), .DATA_IN(DATA_IN), .DATA_OUT(DATA_OUT), .WR(WR),
		.MOSI(MOSI), .MISO(MISO), .SCK(SCK), .CSb(CSb),
		.wvalid(wvalid), .wready(wready),
		.memory_address(memory_address), .memory_data(memory_data)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [7:0] pattern_byte(input logic [23:0] a);
		logic [23:0] p;
		p = a * 24'd7 + 24'd3;
		return p[7:0];
	endfunction

	// Word at a flash word address, first byte in the low half.
	function automatic logic [15:0] pattern_word(input logic [22:0] w);
		logic [23:0] a;
		a = {w, 1'b0};
		return {pattern_byte(a + 24'd1), pattern_byte(a)};
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		$display("mismatch %s %s: expected %0h, actual %0h", cur_name, what, exp, act);
		mismatches++;
	endtask

	task automatic report_fault(input string msg);
		$display("%s: %s", cur_name, msg);
		faults++;
	endtask

	task automatic set_test(input int idx, input string name, input logic [15:0] cmd,
			input logic [22:0] waddr, input logic [15:0] count, input logic [15:0] base);
		test_name[idx] = name;
		test_vec[idx]  = '{cmd: cmd, waddr: waddr, count: count, base: base};
	endtask

	task automatic write_reg(input logic [3:0] a, input logic [15:0] d);
		@(posedge CLK);
		ADDRESS <= a;
		DATA_IN <= d;
		WR      <= 1'b1;
		@(posedge CLK);
		WR <= 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] a, output logic [15:0] d);
		@(posedge CLK);
		ADDRESS <= a;
		@(negedge CLK);
		d = DATA_OUT;
	endtask

	// One table row ------------------------
	task automatic run_test(input int idx);
		test_vec_t   v;
		logic [15:0] st, d, words, exp_writes, frames0, wakes0, exp_data, exp_addr;
		int          n, p, csb_up_at, acc0, n_acc;
		int unsigned wv0;
		logic        is_read, done, status_bad;
		v          = test_vec[idx];
		cur_name   = test_name[idx];
		is_read    = v.cmd[0];	// Read wins over wake.
		words      = (v.count == 16'd0) ? 16'd1 : v.count;
		exp_writes = is_read ? v.count : 16'd0;
		frames0    = frame_count;
		wakes0     = wake_count;
		acc0       = acc_addr.size();
		wv0        = wvalid_cycles;

		write_reg(`REG_ADDR_LO, v.waddr[15:0]);
		write_reg(`REG_ADDR_HI, {9'd0, v.waddr[22:16]});
		write_reg(`REG_DMA_BASE, v.base);
		write_reg(`REG_DMA_COUNT, v.count);
		write_reg(`REG_CMD, v.cmd);

		n = 0;
		do begin
			@(posedge CLK);
			n++;
			@(negedge CLK);
		end while (CSb && n < 16);
		if (CSb)
			report_fault("CSb did not fall after the command write");
		else if (n != 2)
			report_mismatch("csb_delay", 32'd2, 32'(n));

		write_reg(`REG_CMD, 16'h0001);	// Busy, must be dropped.

		done       = 1'b0;
		status_bad = 1'b0;
		p          = 0;
		csb_up_at  = -1;
		while (!done) begin
			read_reg(`REG_STATUS, st);
			if (!CSb && st[1:0] != 2'b10 && !status_bad) begin
				report_mismatch("status_while_active", 32'h2, 32'(st));
				status_bad = 1'b1;
			end
			if (CSb && csb_up_at < 0)
				csb_up_at = p;
			done = st[0];
			p++;
		end
		// A DMA job also waits for the last write, so done comes later there.
		if (!CSb)
			report_fault("CSb still low after done was set");
		else if (exp_writes == 16'd0 && p - 1 - csb_up_at != 1)
			report_mismatch("done_delay", 32'd1, 32'(p - 1 - csb_up_at));
		if (wvalid)
			report_fault("wvalid still high after done was set");
		if (st != 16'h0001)
			report_mismatch("status_after_job", 32'h1, 32'(st));

		if (is_read)
			last_word = pattern_word(v.waddr + 23'(words) - 23'd1);
		exp_data = last_word;
		read_reg(`REG_DATA, d);
		if (d != exp_data)
			report_mismatch("data_reg", 32'(exp_data), 32'(d));

		if (frame_count - frames0 != 16'd1)
			report_mismatch("csb_frames", 32'd1, 32'(frame_count - frames0));
		if (is_read) begin
			if (last_opcode != `OPC_READ)
				report_mismatch("opcode", 32'(`OPC_READ), 32'(last_opcode));
			if (last_addr != {v.waddr, 1'b0})
				report_mismatch("byte_addr", 32'({v.waddr, 1'b0}), 32'(last_addr));
			if (last_bits != 16'd32 + (words << 4))
				report_mismatch("sck_bits", 32'(16'd32 + (words << 4)), 32'(last_bits));
		end else begin
			if (last_opcode != `OPC_WAKE)
				report_mismatch("opcode", 32'(`OPC_WAKE), 32'(last_opcode));
			if (wake_count - wakes0 != 16'd1)
				report_mismatch("wake_count", 32'd1, 32'(wake_count - wakes0));
			if (last_bits != 16'd8)
				report_mismatch("sck_bits", 32'd8, 32'(last_bits));
		end

		n_acc = acc_addr.size() - acc0;
		if (n_acc != int'(exp_writes)) begin
			report_mismatch("write_count", 32'(exp_writes), 32'(n_acc));
		end else begin
			for (int i = 0; i < n_acc; i++) begin
				exp_addr = v.base + 16'(i);
				exp_data = pattern_word(v.waddr + 23'(i));
				if (acc_addr[acc0 + i] != exp_addr)
					report_mismatch("write_addr", 32'(exp_addr), 32'(acc_addr[acc0 + i]));
				if (acc_data[acc0 + i] != exp_data)
					report_mismatch("write_data", 32'(exp_data), 32'(acc_data[acc0 + i]));
			end
		end
		if (exp_writes == 16'd0 && wvalid_cycles != wv0)
			report_fault("wvalid rose on a job without DMA");
	endtask

	// Random back-pressure on the memory port.
	// Each level lasts up to 256 cycles, long enough to stall the engine between words.
	initial begin
		rng    = LCG_SEED;
		wready = 1'b0;
		forever begin
			@(posedge CLK);
			rng = lcg_next(rng);
			wready <= rng[16];
			repeat (rng[24:17]) @(posedge CLK);
		end
	end

	// Memory side monitor.
	always @(posedge CLK) begin
		if (RSTb && wvalid) begin
			wvalid_cycles = wvalid_cycles + 1;
			if (wready) begin
				acc_addr.push_back(memory_address);
				acc_data.push_back(memory_data);
			end
		end
	end

	// Watchdog -----------------------------
	initial begin
		int limit;
		@(posedge CLK);
		limit = TIMEOUT_MARGIN;
		for (int k = 0; k < NUM_TESTS; k++)
			limit = limit + (256 + 128 * (int'(test_vec[k].count) + 1)) * 4;
		repeat (limit) @(posedge CLK);
		$display("watchdog expired after %0d cycles with tests still running", limit);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		ADDRESS = `REG_STATUS;
		DATA_IN = 16'h0000;
		WR      = 1'b0;
		set_test(0, "single_read",    16'h0001, 23'h000123, 16'd0, 16'h0000);
		set_test(1, "wake",           16'h0002, 23'h000000, 16'd0, 16'h0000);
		set_test(2, "dma_four_words", 16'h0001, 23'h001000, 16'd4, 16'h0200);
		set_test(3, "read_wins",      16'h0003, 23'h7ffffe, 16'd0, 16'h0000);
		set_test(4, "dma_wrap_base",  16'h0001, 23'h45a5a5, 16'd8, 16'hfffc);
		set_test(5, "wake_again",     16'h0002, 23'h000000, 16'd0, 16'h0000);
		set_test(6, "dma_one_word",   16'h0001, 23'h000007, 16'd1, 16'h1234);

		wait (RSTb == 1'b1);
		@(negedge CLK);
		cur_name = "after_reset";
		if (!CSb)
			report_fault("CSb low after reset");
		if (SCK)
			report_fault("SCK high after reset");
		if (MOSI)
			report_fault("MOSI high after reset");
		if (wvalid)
			report_fault("wvalid high after reset");
		if (DATA_OUT != 16'h0000)
			report_mismatch("status", 32'h0, 32'(DATA_OUT));

		for (int i = 0; i < NUM_TESTS; i++)
			run_test(i);

		$display("mismatches: %0d, other errors: %0d", mismatches, faults);
		if (mismatches == 0 && faults == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== verif/flash_model.sv ====
/*
 * Behavioral SPI NOR flash in mode 0, for simulation only.
 * Opcode 03h streams byte (a * 7 + 3) from byte address a onward; ABh is only counted.
 * Any other opcode is ignored and MISO then holds its last value.
 */
`timescale 1ns/1ps
`include "spi_flash_consts.svh"

module flash_model (
	input  logic        CSb,
	input  logic        SCK,
	input  logic        MOSI,
	output logic        MISO,
	output logic [15:0] frame_count,
	output logic [15:0] wake_count,
	output logic [7:0]  last_opcode,
	output logic [23:0] last_addr,
	output logic [15:0] last_bits
);
	logic [15:0] frames    = '0;
	logic [15:0] wakes     = '0;
	logic [15:0] in_frame  = '0;	// Frame the input counters belong to.
	logic [15:0] out_frame = '0;
	logic [31:0] in_sr     = '0;
	logic [15:0] in_cnt    = '0;	// Rising SCK edges in this frame.
	logic [15:0] out_cnt   = '0;
	logic [7:0]  opcode    = '0;
	logic [23:0] addr      = '0;
	logic [15:0] bits      = '0;
	logic        miso_q    = 1'b0;

	// Bit n of the byte stream that starts at byte address start.
	function automatic logic data_bit(input logic [23:0] start, input logic [15:0] n);
		logic [23:0] a;
		logic [23:0] p;
		a = start + {11'd0, n[15:3]};
		p = a * 24'd7 + 24'd3;
		return p[3'd7 - n[2:0]];
	endfunction

	always @(negedge CSb)
		frames = frames + 16'd1;

	always @(posedge CSb)
		bits = in_cnt;

	// Opcode and address in ----------------
	always @(posedge SCK) begin
		if (!CSb) begin
			if (in_frame != frames) begin
				in_frame = frames;
				in_cnt   = '0;
				in_sr    = '0;
			end
			in_sr  = {in_sr[30:0], MOSI};
			in_cnt = in_cnt + 16'd1;
			if (in_cnt == 16'd8) begin
				opcode = in_sr[7:0];
				if (in_sr[7:0] == `OPC_WAKE)
					wakes = wakes + 16'd1;
			end
			if (in_cnt == 16'd32)
				addr = in_sr[23:0];
		end
	end

	// Data out on falling SCK, MSB first.
	always @(negedge SCK) begin
		if (!CSb && opcode == `OPC_READ && in_cnt >= 16'd32) begin
			if (out_frame != frames) begin
				out_frame = frames;
				out_cnt   = '0;
			end
			miso_q <= data_bit(addr, out_cnt);
			out_cnt = out_cnt + 16'd1;
		end
	end

	assign MISO        = miso_q;
	assign frame_count = frames;
	assign wake_count  = wakes;
	assign last_opcode = opcode;
	assign last_addr   = addr;
	assign last_bits   = bits;

endmodule

// ==== verif/clock_gen.sv ====
/*
 * Free-running testbench clock and synchronous active-low reset.
 * RSTb is released on the rising edge after RESET_CYCLES edges.
 */
`timescale 1ns/1ps

module clock_gen #(
	parameter int HALF_PERIOD_NS = 10,	// 20 ns period.
	parameter int RESET_CYCLES   = 4
) (
	output logic CLK,
	output logic RSTb
);
	initial begin
		CLK = 1'b0;
		forever #(HALF_PERIOD_NS) CLK = ~CLK;
	end

	initial begin
		RSTb = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		RSTb <= 1'b1;
	end

endmodule

// ==== rtl/spi_flash_top.sv ====
/*
 * SPI NOR flash reader with host registers and a DMA write port.
 * Read opcode 03h only; SCK runs at CLK / 8.
 */
`timescale 1ns/1ps

module spi_flash_top (
	input  logic        CLK,
	input  logic        RSTb,
	input  logic [3:0]  ADDRESS,
	input  logic [15:0] DATA_IN,
	output logic [15:0] DATA_OUT,
	input  logic        WR,
	output logic        MOSI,
	input  logic        MISO,
	output logic        SCK,
	output logic        CSb,
	output logic        wvalid,
	input  logic        wready,
	output logic [15:0] memory_address,
	output logic [15:0] memory_data
);
	import spi_flash_pkg::*;

	logic        start, busy, finish;
	logic        rx_strobe, beat_strobe, hold;
	logic [15:0] rx_word;
	flash_job_t  job;
	mem_beat_t   beat;

	flash_regs u_regs (
		.CLK(CLK), .RSTb(RSTb),
		.ADDRESS(ADDRESS), .DATA_IN(DATA_IN), .WR(WR), .DATA_OUT(DATA_OUT),
		.busy(busy), .finish(finish),
		.rx_strobe(rx_strobe), .rx_word(rx_word),
		.start(start), .job(job)
	);

	spi_sequencer u_seq (
		.CLK(CLK), .RSTb(RSTb),
		.start(start), .job(job), .hold(hold),
		.MISO(MISO), .CSb(CSb), .SCK(SCK), .MOSI(MOSI),
		.busy(busy), .finish(finish),
		.rx_strobe(rx_strobe), .rx_word(rx_word),
		.beat_strobe(beat_strobe), .beat(beat)
	);

	dma_writer u_dma (
		.CLK(CLK), .RSTb(RSTb),
		.beat_strobe(beat_strobe), .beat(beat),
		.wready(wready), .wvalid(wvalid),
		.memory_address(memory_address), .memory_data(memory_data),
		.hold(hold)
	);

endmodule

// ==== rtl/dma_writer.sv ====
/*
 * One-entry write buffer for the memory port.
 * A new beat must not arrive while hold is high; the sequencer stalls for that.
 */
`timescale 1ns/1ps

module dma_writer (
	input  logic                     CLK,
	input  logic                     RSTb,
	input  logic                     beat_strobe,
	input  spi_flash_pkg::mem_beat_t beat,
	input  logic                     wready,
	output logic                     wvalid,
	output logic [15:0]              memory_address,
	output logic [15:0]              memory_data,
	output logic                     hold
);
	import spi_flash_pkg::*;

	mem_beat_t held_q;
	logic      valid_q;

	// Valid flag ----------------------------
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			valid_q <= 1'b0;
		end else begin
			if (beat_strobe)
				valid_q <= 1'b1;
			else if (wready)
				valid_q <= 1'b0;	// Taken this cycle.
		end
	end

	// Held beat, stable while valid.
	always_ff @(posedge CLK) begin
		if (beat_strobe)
			held_q <= beat;
	end

	// Memory port ---------------------------
	assign wvalid         = valid_q;
	assign memory_address = held_q.addr;
	assign memory_data    = held_q.data;

	// Stalls the serial engine at the next word boundary.
	assign hold = valid_q;

endmodule

// ==== rtl/spi_sequencer.sv ====
/*
 * SPI mode 0 engine. Pins are registered one cycle behind the FSM.
 * Each received word is byte swapped so the first byte lands low.
 * Stalls between words while the DMA writer still holds a word.
 */
`timescale 1ns/1ps
`include "spi_flash_consts.svh"

module spi_sequencer (
	input  logic                     CLK,
	input  logic                     RSTb,
	input  logic                     start,
	input  spi_flash_pkg::flash_job_t job,
	input  logic                     hold,
	input  logic                     MISO,
	output logic                     CSb,
	output logic                     SCK,
	output logic                     MOSI,
	output logic                     busy,
	output logic                     finish,
	output logic                     rx_strobe,
	output logic [15:0]              rx_word,
	output logic                     beat_strobe,
	output spi_flash_pkg::mem_beat_t beat
);
	import spi_flash_pkg::*;

	localparam int TICK_W = $clog2(`SPI_TICKS_PER_BIT);
	localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(`SPI_TICKS_PER_BIT - 1);
	localparam logic [TICK_W-1:0] RISE_TICK = TICK_W'(`SPI_SCK_RISE);

	typedef enum logic [2:0] {
		S_IDLE, S_OPCODE, S_ADDRESS, S_DATA, S_STALL, S_FINISH
	} seq_state_t;

	seq_state_t        state_q;
	logic [TICK_W-1:0] tick_q;
	logic [4:0]        bit_q;
	logic [23:0]       sr_q;		// Opcode, then byte address.
	logic [15:0]       rx_sr_q;
	logic [15:0]       rx_word_q;
	logic [15:0]       words_left_q;
	logic [15:0]       word_idx_q;
	logic              csb_q, sck_q, mosi_q;
	logic              finish_q, rx_strobe_q, beat_strobe_q;
	mem_beat_t         beat_q;

	logic        shifting, bit_end, word_end, dma_job, beat_fire;
	logic [15:0] swapped;

	assign shifting  = (state_q == S_OPCODE) || (state_q == S_ADDRESS) || (state_q == S_DATA);
	assign bit_end   = shifting && (tick_q == LAST_TICK);
	assign word_end  = (state_q == S_DATA) && bit_end && (bit_q == 5'd15);
	assign dma_job   = (job.count != 16'd0);
	assign beat_fire = (word_end && dma_job && !hold) || ((state_q == S_STALL) && !hold);
	assign swapped   = {rx_sr_q[7:0], rx_sr_q[15:8]};

	// Control -------------------------------
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state_q       <= S_IDLE;
			tick_q        <= '0;
			bit_q         <= '0;
			words_left_q  <= '0;
			word_idx_q    <= '0;
			csb_q         <= 1'b1;
			sck_q         <= 1'b0;
			mosi_q        <= 1'b0;
			finish_q      <= 1'b0;
			rx_strobe_q   <= 1'b0;
			beat_strobe_q <= 1'b0;
		end else begin
			csb_q         <= !(shifting || (state_q == S_STALL));
			sck_q         <= shifting && (tick_q >= RISE_TICK);
			mosi_q        <= ((state_q == S_OPCODE) || (state_q == S_ADDRESS)) && sr_q[23];
			finish_q      <= 1'b0;
			rx_strobe_q   <= word_end;
			beat_strobe_q <= beat_fire;
			if (shifting)
				tick_q <= bit_end ? '0 : tick_q + 1'b1;
			if (bit_end)
				bit_q <= bit_q + 1'b1;
			if (beat_fire)
				word_idx_q <= word_idx_q + 1'b1;
			case (state_q)
				S_IDLE:
					if (start) begin
						state_q      <= S_OPCODE;
						tick_q       <= '0;
						bit_q        <= '0;
						word_idx_q   <= '0;
						words_left_q <= dma_job ? job.count : 16'd1;
					end
				S_OPCODE:
					if (bit_end && bit_q == 5'd7) begin
						bit_q   <= '0;
						state_q <= (job.op == OP_WAKE) ? S_FINISH : S_ADDRESS;
					end
				S_ADDRESS:
					if (bit_end && bit_q == 5'd23) begin
						bit_q   <= '0;
						state_q <= S_DATA;
					end
				S_DATA:
					if (word_end) begin
						bit_q        <= '0;
						words_left_q <= words_left_q - 1'b1;
						if (dma_job && hold)
							state_q <= S_STALL;	// Previous word not yet taken.
						else if (words_left_q == 16'd1)
							state_q <= S_FINISH;
					end
				S_STALL:
					if (!hold)
						state_q <= (words_left_q == 16'd0) ? S_FINISH : S_DATA;
				S_FINISH:
					if (!hold && !beat_strobe_q) begin	// Last write accepted.
						finish_q <= 1'b1;
						state_q  <= S_IDLE;
					end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// Shift registers and word capture.
	always_ff @(posedge CLK) begin
		if (state_q == S_IDLE && start)
			sr_q <= {(job.op == OP_WAKE) ? `OPC_WAKE : `OPC_READ, 16'h0000};
		else if (state_q == S_OPCODE && bit_end && bit_q == 5'd7)
			sr_q <= {job.word_addr, 1'b0};	// Byte address.
		else if (bit_end && state_q != S_DATA)
			sr_q <= {sr_q[22:0], 1'b0};
		if (state_q == S_DATA && tick_q == RISE_TICK)
			rx_sr_q <= {rx_sr_q[14:0], MISO};
		if (word_end)
			rx_word_q <= swapped;
		if (beat_fire)
			beat_q <= '{addr: job.dma_base + word_idx_q, data: word_end ? swapped : rx_word_q};
	end

	assign CSb         = csb_q;
	assign SCK         = sck_q;
	assign MOSI        = mosi_q;
	assign busy        = (state_q != S_IDLE) || finish_q;
	assign finish      = finish_q;
	assign rx_strobe   = rx_strobe_q;
	assign rx_word     = rx_word_q;
	assign beat_strobe = beat_strobe_q;
	assign beat        = beat_q;

endmodule

// ==== rtl/flash_regs.sv ====
/*
 * Host register port. Reads are combinational from ADDRESS.
 * Command writes while a job is running or launching are dropped.
 */
`timescale 1ns/1ps
`include "spi_flash_consts.svh"

module flash_regs (
	input  logic                     CLK,
	input  logic                     RSTb,
	input  logic [3:0]               ADDRESS,
	input  logic [15:0]              DATA_IN,
	input  logic                     WR,
	output logic [15:0]              DATA_OUT,
	input  logic                     busy,
	input  logic                     finish,
	input  logic                     rx_strobe,
	input  logic [15:0]              rx_word,
	output logic                     start,
	output spi_flash_pkg::flash_job_t job
);
	import spi_flash_pkg::*;

	logic [15:0] addr_lo_q;
	logic [6:0]  addr_hi_q;
	logic [15:0] dma_base_q;
	logic [15:0] dma_count_q;
	logic [15:0] data_q;
	logic        done_q;
	logic        start_q;
	flash_job_t  job_q;
	logic        job_busy;
	logic        launch;

	assign job_busy = busy | start_q;	// Covers the cycle before the engine leaves idle.
	assign launch   = WR && (ADDRESS == `REG_CMD) && (DATA_IN[1:0] != 2'b00) && !job_busy;

	assign start = start_q;
	assign job   = job_q;

	// Control and configuration -------------
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			addr_lo_q   <= '0;
			addr_hi_q   <= '0;
			dma_base_q  <= '0;
			dma_count_q <= '0;
			start_q     <= 1'b0;
			done_q      <= 1'b0;
		end else begin
			start_q <= launch;
			if (launch)
				done_q <= 1'b0;
			else if (finish)
				done_q <= 1'b1;
			if (WR) begin
				case (ADDRESS)
					`REG_ADDR_LO:   addr_lo_q   <= DATA_IN;
					`REG_ADDR_HI:   addr_hi_q   <= DATA_IN[6:0];
					`REG_DMA_BASE:  dma_base_q  <= DATA_IN;
					`REG_DMA_COUNT: dma_count_q <= DATA_IN;
					default: ;
				endcase
			end
		end
	end

	// Job snapshot and received word.
	always_ff @(posedge CLK) begin
		if (launch) begin
			job_q <= '{
				op:        (DATA_IN[0] ? OP_READ : OP_WAKE),	// Read wins.
				word_addr: {addr_hi_q, addr_lo_q},
				count:     dma_count_q,
				dma_base:  dma_base_q
			};
		end
		if (rx_strobe)
			data_q <= rx_word;
	end

	// Read mux ------------------------------
	always_comb begin
		case (ADDRESS)
			`REG_DATA:   DATA_OUT = data_q;
			`REG_STATUS: DATA_OUT = {14'd0, job_busy, done_q};
			default:     DATA_OUT = 16'h0000;
		endcase
	end

endmodule

// ==== rtl/spi_flash_pkg.sv ====
/*
 * Types shared by the register front end, the serial engine and the DMA writer.
 */
package spi_flash_pkg;

	// Operation requested by a command write.
	typedef enum logic {
		OP_READ = 1'b0,
		OP_WAKE = 1'b1
	} flash_op_t;

	// Job snapshot taken when a command is launched.
	typedef struct packed {
		flash_op_t   op;
		logic [22:0] word_addr;	// 16-bit word address in flash.
		logic [15:0] count;		// Words to DMA, zero for register only.
		logic [15:0] dma_base;	// First memory address.
	} flash_job_t;

	// One word bound for memory.
	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] data;
	} mem_beat_t;

endpackage

// ==== rtl/spi_flash_consts.svh ====
/*
 * Register map, opcodes and serial timing for the SPI flash reader.
 * SCK is fixed at SPI_TICKS_PER_BIT clocks per bit; there is no divider register.
 */
`ifndef SPI_FLASH_CONSTS_SVH
`define SPI_FLASH_CONSTS_SVH

// Serial timing ---------------------------
`define SPI_TICKS_PER_BIT	8	// CLK cycles per SCK bit.
`define SPI_SCK_RISE		4	// SCK rises and MISO is sampled here.

// Host register indices -------------------
`define REG_ADDR_LO		4'd0	// Word address bits 15:0.
`define REG_ADDR_HI		4'd1	// Word address bits 22:16.
`define REG_CMD			4'd2	// Bit 0 read, bit 1 wake.
`define REG_DATA		4'd3
`define REG_STATUS		4'd4	// Bit 0 done, bit 1 busy.
`define REG_DMA_BASE	4'd5
`define REG_DMA_COUNT	4'd6	// Zero means no DMA.

// Flash opcodes
`define OPC_READ		8'h03
`define OPC_WAKE		8'hAB

`endif
